// File: verilog.f
source/soc_pkg.sv
source/soc_icache_sram.sv
source/soc_icache.sv
source/soc_arbiter.sv
source/soc_clint_xbar.sv
source/soc_clint.sv
source/soc_top.sv
testbench/tb_axi_mem.sv
testbench/tb_soc_top.sv

// File: testbench/tb_soc_top.sv
`timescale 1ns/1ns

module tb_soc_top;

  localparam int MAX_CYCLES = 20000;

  logic clock, rst_i;
  logic fetch_valid_i, fetch_done_o;
  soc_pkg::addr_t fetch_addr_i;
  soc_pkg::word_t fetch_instr_o;
  logic lsu_awvalid_i, lsu_awready_o, lsu_wvalid_i, lsu_wready_o;
  logic lsu_bvalid_o, lsu_bready_i, lsu_arvalid_i, lsu_arready_o;
  logic lsu_rvalid_o, lsu_rready_i;
  soc_pkg::addr_t lsu_awaddr_i, lsu_araddr_i;
  soc_pkg::word_t lsu_wdata_i, lsu_rdata_o;
  soc_pkg::strb_t lsu_wstrb_i;
  soc_pkg::resp_t lsu_bresp_o, lsu_rresp_o;
  logic master_awvalid_o, master_awready_i, master_wvalid_o, master_wready_i;
  logic master_bvalid_i, master_bready_o, master_arvalid_o, master_arready_i;
  logic master_rvalid_i, master_rready_o, master_rlast_i;
  soc_pkg::addr_t master_awaddr_o, master_araddr_o;
  soc_pkg::word_t master_wdata_o, master_rdata_i;
  soc_pkg::strb_t master_wstrb_o;
  soc_pkg::resp_t master_bresp_i, master_rresp_i;
  soc_pkg::len_t  master_arlen_o;
  logic timer_irq_o;

  // Expectations set by the stimulus
  int             cyc;
  logic           exp_hit, exp_miss, refill_seen, fetch_q;
  logic           rd_exact, irq_check;
  logic           irq_exp;
  soc_pkg::word_t exp_rdata, last_mtime;

  soc_top #(.IC_INDEX_W(4)) soc_top_i (.*);

  tb_axi_mem mem_i (
    .clock(clock), .rst_i(rst_i),
    .awvalid_i(master_awvalid_o), .awready_o(master_awready_i), .awaddr_i(master_awaddr_o),
    .wvalid_i(master_wvalid_o), .wready_o(master_wready_i), .wdata_i(master_wdata_o),
    .wstrb_i(master_wstrb_o),
    .bvalid_o(master_bvalid_i), .bready_i(master_bready_o), .bresp_o(master_bresp_i),
    .arvalid_i(master_arvalid_o), .arready_o(master_arready_i), .araddr_i(master_araddr_o),
    .arlen_i(master_arlen_o),
    .rvalid_o(master_rvalid_i), .rready_i(master_rready_o), .rdata_o(master_rdata_i),
    .rresp_o(master_rresp_i), .rlast_o(master_rlast_i)
  );

  task automatic report_failure();
    $display("** FAIL **");
    $fatal(1, "run stopped on first error");
  endtask

  function automatic soc_pkg::word_t base_word(soc_pkg::addr_t addr);
    return addr ^ 32'h5a5a_5a5a;
  endfunction

  function automatic soc_pkg::word_t merged_word(soc_pkg::word_t old_v, soc_pkg::word_t new_v,
                                                 soc_pkg::strb_t strb);
    soc_pkg::word_t res;
    res = old_v;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = new_v[i*8 +: 8];
      end
    end
    return res;
  endfunction

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cyc     <= cyc + 1;
    fetch_q <= fetch_valid_i;
    if (fetch_valid_i && !fetch_q) begin
      refill_seen <= 1'b0;
    end else if (master_arvalid_o && master_arready_i && master_arlen_o == 8'd3) begin
      refill_seen <= 1'b1;
    end
    if (cyc == MAX_CYCLES) begin
      $display("timeout: stimulus did not complete within %0d cycles", MAX_CYCLES);
      report_failure();
    end
  end

  reset_low_a : assert property (@(posedge clock) (cyc > 0 && cyc <= 12) |->
    !(fetch_done_o || timer_irq_o || master_awvalid_o || master_wvalid_o ||
      master_arvalid_o || master_bready_o || master_rready_o || lsu_awready_o ||
      lsu_wready_o || lsu_arready_o || lsu_bvalid_o || lsu_rvalid_o))
    else begin
      $display("outputs not low during or right after reset at %0t", $time);
      report_failure();
    end

  fetch_data_a : assert property (@(posedge clock) fetch_done_o |->
    fetch_instr_o == base_word(fetch_addr_i))
    else begin
      $display("mismatch at %0t: fetch_instr_o expected %h got %h", $time,
               base_word($sampled(fetch_addr_i)), $sampled(fetch_instr_o));
      report_failure();
    end

  hit_timing_a : assert property (@(posedge clock) exp_hit && $rose(fetch_valid_i) |=>
    fetch_done_o)
    else begin
      $display("mismatch at %0t: fetch_done_o expected 1 got 0 one cycle after hit", $time);
      report_failure();
    end

  hit_no_read_a : assert property (@(posedge clock) exp_hit && fetch_valid_i |->
    !master_arvalid_o)
    else begin
      $display("master read issued during a cache hit at %0t", $time);
      report_failure();
    end

  miss_refill_a : assert property (@(posedge clock) exp_miss && fetch_done_o |-> refill_seen)
    else begin
      $display("fetch miss finished without a line refill at %0t", $time);
      report_failure();
    end

  // Data reads live at 0x8xxx_xxxx, fetches below
  arlen_a : assert property (@(posedge clock) master_arvalid_o |->
    master_arlen_o == (master_araddr_o[31] ? 8'd0 : 8'd3) &&
    (master_araddr_o[31] || master_araddr_o[3:0] == 4'h0))
    else begin
      $display("mismatch at %0t: master_arlen_o expected %0d got %0d", $time,
               $sampled(master_araddr_o[31]) ? 0 : 3, $sampled(master_arlen_o));
      report_failure();
    end

  rdata_a : assert property (@(posedge clock) lsu_rvalid_o && lsu_rready_i |->
    (rd_exact ? lsu_rdata_o == exp_rdata : lsu_rdata_o > last_mtime) &&
    lsu_rresp_o == soc_pkg::RESP_OKAY)
    else begin
      $display("mismatch at %0t: lsu_rdata_o expected %h got %h (resp %0d)", $time,
               rd_exact ? exp_rdata : last_mtime, $sampled(lsu_rdata_o),
               $sampled(lsu_rresp_o));
      report_failure();
    end

  bresp_a : assert property (@(posedge clock) lsu_bvalid_o |->
    lsu_bresp_o == soc_pkg::RESP_OKAY)
    else begin
      $display("mismatch at %0t: lsu_bresp_o expected 0 got %0d", $time,
               $sampled(lsu_bresp_o));
      report_failure();
    end

  irq_a : assert property (@(posedge clock) irq_check |-> timer_irq_o == irq_exp)
    else begin
      $display("mismatch at %0t: timer_irq_o expected %b got %b", $time,
               irq_exp, $sampled(timer_irq_o));
      report_failure();
    end

  task automatic fetch_word(soc_pkg::addr_t addr, logic hit);
    @(negedge clock);
    fetch_valid_i = 1'b1;
    fetch_addr_i  = addr;
    exp_hit       = hit;
    exp_miss      = !hit;
    while (!fetch_done_o) @(negedge clock);
    @(negedge clock);
    fetch_valid_i = 1'b0;
    exp_hit       = 1'b0;
    exp_miss      = 1'b0;
    @(negedge clock);
  endtask

  task automatic write_data(soc_pkg::addr_t addr, soc_pkg::word_t data, soc_pkg::strb_t strb);
    logic aw_ok, w_ok;
    @(negedge clock);
    lsu_awvalid_i = 1'b1;
    lsu_awaddr_i  = addr;
    lsu_wvalid_i  = 1'b1;
    lsu_wdata_i   = data;
    lsu_wstrb_i   = strb;
    while (lsu_awvalid_i || lsu_wvalid_i) begin
      #1;
      aw_ok = lsu_awvalid_i && lsu_awready_o;
      w_ok  = lsu_wvalid_i && lsu_wready_o;
      @(negedge clock);
      if (aw_ok) lsu_awvalid_i = 1'b0;
      if (w_ok) lsu_wvalid_i = 1'b0;
    end
    #1;
    while (!lsu_bvalid_o) begin
      @(negedge clock);
      #1;
    end
    @(negedge clock);
  endtask

  task automatic read_data(soc_pkg::addr_t addr, logic exact, soc_pkg::word_t exp);
    soc_pkg::word_t got;
    @(negedge clock);
    rd_exact      = exact;
    exp_rdata     = exp;
    lsu_arvalid_i = 1'b1;
    lsu_araddr_i  = addr;
    #1;
    while (!lsu_arready_o) begin
      @(negedge clock);
      #1;
    end
    @(negedge clock);
    lsu_arvalid_i = 1'b0;
    #1;
    while (!lsu_rvalid_o) begin
      @(negedge clock);
      #1;
    end
    got = lsu_rdata_o;
    // Beat is compared with the previous mtime before this one replaces it
    @(negedge clock);
    if (!exact) last_mtime = got;
  endtask

  task automatic wait_irq(logic level);
    irq_check = 1'b0;
    irq_exp   = level;
    while (timer_irq_o != level) @(negedge clock);
    irq_check = 1'b1;
    repeat (5) @(negedge clock);
  endtask

  initial begin
    cyc = 0;
    rst_i = 1'b1;
    fetch_valid_i = 1'b0;
    fetch_addr_i = '0;
    lsu_awvalid_i = 1'b0;
    lsu_awaddr_i = '0;
    lsu_wvalid_i = 1'b0;
    lsu_wdata_i = '0;
    lsu_wstrb_i = '0;
    lsu_bready_i = 1'b1;
    lsu_arvalid_i = 1'b0;
    lsu_araddr_i = '0;
    lsu_rready_i = 1'b1;
    exp_hit = 1'b0;
    exp_miss = 1'b0;
    refill_seen = 1'b0;
    fetch_q = 1'b0;
    rd_exact = 1'b1;
    irq_check = 1'b0;
    irq_exp = 1'b0;
    exp_rdata = '0;
    last_mtime = '0;
    repeat (10) @(negedge clock);
    rst_i = 1'b0;
    repeat (4) @(negedge clock);

    fetch_word(32'h0000_1000, 1'b0);
    fetch_word(32'h0000_1004, 1'b1);
    fetch_word(32'h0000_1000, 1'b1);
    // Same index, other tag
    fetch_word(32'h0000_2000, 1'b0);
    fetch_word(32'h0000_1008, 1'b0);

    write_data(32'h8000_0040, 32'h1122_3344, 4'b0101);
    read_data(32'h8000_0040, 1'b1,
              merged_word(base_word(32'h8000_0040), 32'h1122_3344, 4'b0101));

    read_data(soc_pkg::CLINT_BASE + soc_pkg::MTIME_LO, 1'b0, '0);
    repeat (20) @(negedge clock);
    read_data(soc_pkg::CLINT_BASE + soc_pkg::MTIME_LO, 1'b0, '0);

    write_data(soc_pkg::CLINT_BASE + soc_pkg::MTIMECMP_HI, 32'h0, 4'hf);
    write_data(soc_pkg::CLINT_BASE + soc_pkg::MTIMECMP_LO, 32'h0, 4'hf);
    wait_irq(1'b1);
    write_data(soc_pkg::CLINT_BASE + soc_pkg::MTIMECMP_HI, 32'hffff_ffff, 4'hf);
    wait_irq(1'b0);
    irq_check = 1'b0;

    // Refill and data read racing for the master port
    fork
      fetch_word(32'h0000_3010, 1'b0);
      read_data(32'h8000_0100, 1'b1, base_word(32'h8000_0100));
    join

    repeat (5) @(negedge clock);
    $display("** PASS **");
    $finish;
  end

endmodule

// File: testbench/tb_axi_mem.sv
`timescale 1ns/1ns

module tb_axi_mem (
  input  logic           clock,
  input  logic           rst_i,
  input  logic           awvalid_i,
  output logic           awready_o,
  input  soc_pkg::addr_t awaddr_i,
  input  logic           wvalid_i,
  output logic           wready_o,
  input  soc_pkg::word_t wdata_i,
  input  soc_pkg::strb_t wstrb_i,
  output logic           bvalid_o,
  input  logic           bready_i,
  output soc_pkg::resp_t bresp_o,
  input  logic           arvalid_i,
  output logic           arready_o,
  input  soc_pkg::addr_t araddr_i,
  input  soc_pkg::len_t  arlen_i,
  output logic           rvalid_o,
  input  logic           rready_i,
  output soc_pkg::word_t rdata_o,
  output soc_pkg::resp_t rresp_o,
  output logic           rlast_o
);

  soc_pkg::word_t mem[soc_pkg::addr_t];

  // Unwritten words hold a pattern of their own address
  function automatic soc_pkg::word_t read_word(soc_pkg::addr_t addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return addr ^ 32'h5a5a_5a5a;
  endfunction

  function automatic soc_pkg::word_t apply_strobes(soc_pkg::word_t old_v,
                                                   soc_pkg::word_t new_v,
                                                   soc_pkg::strb_t strb);
    soc_pkg::word_t res;
    res = old_v;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = new_v[i*8 +: 8];
      end
    end
    return res;
  endfunction

  // Read channel, incrementing bursts
  task automatic serve_reads();
    soc_pkg::addr_t addr;
    soc_pkg::len_t  len;
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rlast_o   = 1'b0;
    rdata_o   = '0;
    rresp_o   = soc_pkg::RESP_OKAY;
    forever begin
      @(negedge clock);
      if (!rst_i && arvalid_i) begin
        repeat ($urandom % 4) @(negedge clock);
        arready_o = 1'b1;
        // Burst address and length as seen at the handshake edge
        @(posedge clock);
        addr = araddr_i;
        len  = arlen_i;
        @(negedge clock);
        arready_o = 1'b0;
        for (int i = 0; i <= len; i++) begin
          repeat ($urandom % 4) @(negedge clock);
          rvalid_o = 1'b1;
          rdata_o  = read_word(addr + 4 * i);
          rlast_o  = (i == len);
          #1;
          while (!rready_i) begin
            @(negedge clock);
            #1;
          end
          @(negedge clock);
          rvalid_o = 1'b0;
          rlast_o  = 1'b0;
        end
      end
    end
  endtask

  // Write channel, single beats
  task automatic serve_writes();
    soc_pkg::addr_t addr;
    awready_o = 1'b0;
    wready_o  = 1'b0;
    bvalid_o  = 1'b0;
    bresp_o   = soc_pkg::RESP_OKAY;
    forever begin
      @(negedge clock);
      if (!rst_i && awvalid_i) begin
        addr = awaddr_i;
        repeat ($urandom % 4) @(negedge clock);
        awready_o = 1'b1;
        @(negedge clock);
        awready_o = 1'b0;
        while (!wvalid_i) @(negedge clock);
        repeat ($urandom % 4) @(negedge clock);
        wready_o = 1'b1;
        mem[addr] = apply_strobes(read_word(addr), wdata_i, wstrb_i);
        @(negedge clock);
        wready_o = 1'b0;
        repeat ($urandom % 4) @(negedge clock);
        bvalid_o = 1'b1;
        #1;
        while (!bready_i) begin
          @(negedge clock);
          #1;
        end
        @(negedge clock);
        bvalid_o = 1'b0;
      end
    end
  endtask

  // Both channels draw their delays from this one seeded thread
  initial begin
    void'($urandom(32'hc425));
    fork
      serve_reads();
      serve_writes();
    join
  end

endmodule

// File: source/soc_top.sv
`timescale 1ns/1ns

module soc_top #(
  parameter int IC_INDEX_W = 4
) (
  input  logic           clock,
  input  logic           rst_i,
  input  logic           fetch_valid_i,
  input  soc_pkg::addr_t fetch_addr_i,
  output logic           fetch_done_o,
  output soc_pkg::word_t fetch_instr_o,
  input  logic           lsu_awvalid_i,
  output logic           lsu_awready_o,
  input  soc_pkg::addr_t lsu_awaddr_i,
  input  logic           lsu_wvalid_i,
  output logic           lsu_wready_o,
  input  soc_pkg::word_t lsu_wdata_i,
  input  soc_pkg::strb_t lsu_wstrb_i,
  output logic           lsu_bvalid_o,
  input  logic           lsu_bready_i,
  output soc_pkg::resp_t lsu_bresp_o,
  input  logic           lsu_arvalid_i,
  output logic           lsu_arready_o,
  input  soc_pkg::addr_t lsu_araddr_i,
  output logic           lsu_rvalid_o,
  input  logic           lsu_rready_i,
  output soc_pkg::word_t lsu_rdata_o,
  output soc_pkg::resp_t lsu_rresp_o,
  output logic           master_awvalid_o,
  input  logic           master_awready_i,
  output soc_pkg::addr_t master_awaddr_o,
  output logic           master_wvalid_o,
  input  logic           master_wready_i,
  output soc_pkg::word_t master_wdata_o,
  output soc_pkg::strb_t master_wstrb_o,
  input  logic           master_bvalid_i,
  output logic           master_bready_o,
  input  soc_pkg::resp_t master_bresp_i,
  output logic           master_arvalid_o,
  input  logic           master_arready_i,
  output soc_pkg::addr_t master_araddr_o,
  output soc_pkg::len_t  master_arlen_o,
  input  logic           master_rvalid_i,
  output logic           master_rready_o,
  input  soc_pkg::word_t master_rdata_i,
  input  soc_pkg::resp_t master_rresp_i,
  input  logic           master_rlast_i,
  output logic           timer_irq_o
);

  // Cache refill path
  logic           ic_arvalid, ic_arready, ic_rvalid, ic_rready, ic_rlast;
  soc_pkg::addr_t ic_araddr;
  soc_pkg::word_t ic_rdata;

  // Data side bound for external memory
  logic           ext_awvalid, ext_awready, ext_wvalid, ext_wready;
  logic           ext_bvalid, ext_bready, ext_arvalid, ext_arready;
  logic           ext_rvalid, ext_rready;
  soc_pkg::addr_t ext_awaddr, ext_araddr;
  soc_pkg::word_t ext_wdata, ext_rdata;
  soc_pkg::strb_t ext_wstrb;
  soc_pkg::resp_t ext_bresp, ext_rresp;

  logic           clint_req, clint_we;
  logic [3:0]     clint_addr;
  soc_pkg::word_t clint_wdata, clint_rdata;
  soc_pkg::strb_t clint_wstrb;

  soc_icache #(
    .IC_INDEX_W(IC_INDEX_W)
  ) icache_i (
    .*,
    .ic_arvalid_o(ic_arvalid), .ic_arready_i(ic_arready), .ic_araddr_o(ic_araddr),
    .ic_rvalid_i(ic_rvalid), .ic_rready_o(ic_rready), .ic_rdata_i(ic_rdata),
    .ic_rlast_i(ic_rlast)
  );

  soc_arbiter arbiter_i (
    .*,
    .ic_arvalid_i(ic_arvalid), .ic_arready_o(ic_arready), .ic_araddr_i(ic_araddr),
    .ic_rvalid_o(ic_rvalid), .ic_rready_i(ic_rready), .ic_rdata_o(ic_rdata),
    .ic_rlast_o(ic_rlast),
    .ext_awvalid_i(ext_awvalid), .ext_awready_o(ext_awready), .ext_awaddr_i(ext_awaddr),
    .ext_wvalid_i(ext_wvalid), .ext_wready_o(ext_wready), .ext_wdata_i(ext_wdata),
    .ext_wstrb_i(ext_wstrb),
    .ext_bvalid_o(ext_bvalid), .ext_bready_i(ext_bready), .ext_bresp_o(ext_bresp),
    .ext_arvalid_i(ext_arvalid), .ext_arready_o(ext_arready), .ext_araddr_i(ext_araddr),
    .ext_rvalid_o(ext_rvalid), .ext_rready_i(ext_rready), .ext_rdata_o(ext_rdata),
    .ext_rresp_o(ext_rresp)
  );

  soc_clint_xbar clint_xbar_i (
    .*,
    .ext_awvalid_o(ext_awvalid), .ext_awready_i(ext_awready), .ext_awaddr_o(ext_awaddr),
    .ext_wvalid_o(ext_wvalid), .ext_wready_i(ext_wready), .ext_wdata_o(ext_wdata),
    .ext_wstrb_o(ext_wstrb),
    .ext_bvalid_i(ext_bvalid), .ext_bready_o(ext_bready), .ext_bresp_i(ext_bresp),
    .ext_arvalid_o(ext_arvalid), .ext_arready_i(ext_arready), .ext_araddr_o(ext_araddr),
    .ext_rvalid_i(ext_rvalid), .ext_rready_o(ext_rready), .ext_rdata_i(ext_rdata),
    .ext_rresp_i(ext_rresp),
    .clint_req_o(clint_req), .clint_we_o(clint_we), .clint_addr_o(clint_addr),
    .clint_wdata_o(clint_wdata), .clint_wstrb_o(clint_wstrb), .clint_rdata_i(clint_rdata)
  );

  soc_clint clint_i (
    .*,
    .req_i  (clint_req),
    .we_i   (clint_we),
    .addr_i (clint_addr),
    .wdata_i(clint_wdata),
    .wstrb_i(clint_wstrb),
    .rdata_o(clint_rdata)
  );

endmodule

// File: source/soc_clint.sv
`timescale 1ns/1ns

module soc_clint (
  input  logic           clock,
  input  logic           rst_i,
  input  logic           req_i,
  input  logic           we_i,
  input  logic [3:0]     addr_i,
  input  soc_pkg::word_t wdata_i,
  input  soc_pkg::strb_t wstrb_i,
  output soc_pkg::word_t rdata_o,
  output logic           timer_irq_o
);

  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;

  function automatic soc_pkg::word_t merge(soc_pkg::word_t old_v, soc_pkg::word_t new_v,
                                           soc_pkg::strb_t strb);
    soc_pkg::word_t res;
    res = old_v;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = new_v[i*8 +: 8];
      end
    end
    return res;
  endfunction

  always_ff @(posedge clock) begin
    if (rst_i) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      timer_irq_o <= 1'b0;
    end else begin
      mtime_q     <= mtime_q + 64'd1;
      timer_irq_o <= (mtime_q >= mtimecmp_q);
      // A write to mtime overrides the increment for that half
      if (req_i && we_i) begin
        case (addr_i)
          soc_pkg::MTIME_LO:    mtime_q[31:0]     <= merge(mtime_q[31:0], wdata_i, wstrb_i);
          soc_pkg::MTIME_HI:    mtime_q[63:32]    <= merge(mtime_q[63:32], wdata_i, wstrb_i);
          soc_pkg::MTIMECMP_LO: mtimecmp_q[31:0]  <= merge(mtimecmp_q[31:0], wdata_i, wstrb_i);
          soc_pkg::MTIMECMP_HI: mtimecmp_q[63:32] <= merge(mtimecmp_q[63:32], wdata_i, wstrb_i);
          default: ;
        endcase
      end
    end
  end

  // Held until the next read
  always_ff @(posedge clock) begin
    if (req_i && !we_i) begin
      case (addr_i)
        soc_pkg::MTIME_LO:    rdata_o <= mtime_q[31:0];
        soc_pkg::MTIME_HI:    rdata_o <= mtime_q[63:32];
        soc_pkg::MTIMECMP_LO: rdata_o <= mtimecmp_q[31:0];
        soc_pkg::MTIMECMP_HI: rdata_o <= mtimecmp_q[63:32];
        default:              rdata_o <= '0;
      endcase
    end
  end

endmodule

// File: source/soc_clint_xbar.sv
`timescale 1ns/1ns

module soc_clint_xbar (
  input  logic           clock,
  input  logic           rst_i,
  input  logic           lsu_awvalid_i,
  output logic           lsu_awready_o,
  input  soc_pkg::addr_t lsu_awaddr_i,
  input  logic           lsu_wvalid_i,
  output logic           lsu_wready_o,
  input  soc_pkg::word_t lsu_wdata_i,
  input  soc_pkg::strb_t lsu_wstrb_i,
  output logic           lsu_bvalid_o,
  input  logic           lsu_bready_i,
  output soc_pkg::resp_t lsu_bresp_o,
  input  logic           lsu_arvalid_i,
  output logic           lsu_arready_o,
  input  soc_pkg::addr_t lsu_araddr_i,
  output logic           lsu_rvalid_o,
  input  logic           lsu_rready_i,
  output soc_pkg::word_t lsu_rdata_o,
  output soc_pkg::resp_t lsu_rresp_o,
  output logic           ext_awvalid_o,
  input  logic           ext_awready_i,
  output soc_pkg::addr_t ext_awaddr_o,
  output logic           ext_wvalid_o,
  input  logic           ext_wready_i,
  output soc_pkg::word_t ext_wdata_o,
  output soc_pkg::strb_t ext_wstrb_o,
  input  logic           ext_bvalid_i,
  output logic           ext_bready_o,
  input  soc_pkg::resp_t ext_bresp_i,
  output logic           ext_arvalid_o,
  input  logic           ext_arready_i,
  output soc_pkg::addr_t ext_araddr_o,
  input  logic           ext_rvalid_i,
  output logic           ext_rready_o,
  input  soc_pkg::word_t ext_rdata_i,
  input  soc_pkg::resp_t ext_rresp_i,
  output logic           clint_req_o,
  output logic           clint_we_o,
  output logic [3:0]     clint_addr_o,
  output soc_pkg::word_t clint_wdata_o,
  output soc_pkg::strb_t clint_wstrb_o,
  input  soc_pkg::word_t clint_rdata_i
);

  logic busy_q;
  logic write_q;
  logic clint_q;
  logic aw_clint;
  logic ar_clint;
  logic w_ext;
  logic clint_wr;
  logic clint_rd;
  logic req_acc;
  logic rsp_done;

  assign aw_clint = (lsu_awaddr_i & soc_pkg::CLINT_MASK) == soc_pkg::CLINT_BASE;
  assign ar_clint = (lsu_araddr_i & soc_pkg::CLINT_MASK) == soc_pkg::CLINT_BASE;

  // A CLINT write takes aw and w in one cycle; writes have priority over reads
  assign clint_wr = !busy_q && lsu_awvalid_i && lsu_wvalid_i && aw_clint;
  assign clint_rd = !busy_q && !lsu_awvalid_i && lsu_arvalid_i && ar_clint;

  assign ext_awvalid_o = !busy_q && lsu_awvalid_i && !aw_clint;
  assign ext_awaddr_o  = lsu_awaddr_i;
  assign lsu_awready_o = clint_wr || (ext_awvalid_o && ext_awready_i);

  // w may follow its aw by any number of cycles
  assign w_ext         = busy_q ? (write_q && !clint_q) : (lsu_awvalid_i && !aw_clint);
  assign ext_wvalid_o  = lsu_wvalid_i && w_ext;
  assign ext_wdata_o   = lsu_wdata_i;
  assign ext_wstrb_o   = lsu_wstrb_i;
  assign lsu_wready_o  = clint_wr || (ext_wvalid_o && ext_wready_i);

  assign ext_arvalid_o = !busy_q && !lsu_awvalid_i && lsu_arvalid_i && !ar_clint;
  assign ext_araddr_o  = lsu_araddr_i;
  assign lsu_arready_o = clint_rd || (ext_arvalid_o && ext_arready_i);

  assign lsu_bvalid_o = busy_q && write_q && (clint_q || ext_bvalid_i);
  assign lsu_bresp_o  = clint_q ? soc_pkg::RESP_OKAY : ext_bresp_i;
  assign ext_bready_o = busy_q && write_q && !clint_q && lsu_bready_i;

  assign lsu_rvalid_o = busy_q && !write_q && (clint_q || ext_rvalid_i);
  assign lsu_rdata_o  = clint_q ? clint_rdata_i : ext_rdata_i;
  assign lsu_rresp_o  = clint_q ? soc_pkg::RESP_OKAY : ext_rresp_i;
  assign ext_rready_o = busy_q && !write_q && !clint_q && lsu_rready_i;

  assign clint_req_o   = clint_wr || clint_rd;
  assign clint_we_o    = clint_wr;
  assign clint_addr_o  = clint_wr ? lsu_awaddr_i[3:0] : lsu_araddr_i[3:0];
  assign clint_wdata_o = lsu_wdata_i;
  assign clint_wstrb_o = lsu_wstrb_i;

  assign req_acc  = (lsu_awvalid_i && lsu_awready_o) || (lsu_arvalid_i && lsu_arready_o);
  assign rsp_done = (lsu_bvalid_o && lsu_bready_i) || (lsu_rvalid_o && lsu_rready_i);

  always_ff @(posedge clock) begin
    if (rst_i) begin
      busy_q  <= 1'b0;
      write_q <= 1'b0;
      clint_q <= 1'b0;
    end else if (lsu_awvalid_i && lsu_awready_o) begin
      busy_q  <= 1'b1;
      write_q <= 1'b1;
      clint_q <= aw_clint;
    end else if (lsu_arvalid_i && lsu_arready_o) begin
      busy_q  <= 1'b1;
      write_q <= 1'b0;
      clint_q <= ar_clint;
    end else if (rsp_done) begin
      busy_q <= 1'b0;
    end
  end

  single_outstanding_a : assert property (@(posedge clock) disable iff (rst_i)
    req_acc |=> !req_acc until_with rsp_done)
    else $error("second lsu request accepted before response");

endmodule

// File: source/soc_arbiter.sv
`timescale 1ns/1ns

module soc_arbiter (
  input  logic           clock,
  input  logic           rst_i,
  input  logic           ic_arvalid_i,
  output logic           ic_arready_o,
  input  soc_pkg::addr_t ic_araddr_i,
  output logic           ic_rvalid_o,
  input  logic           ic_rready_i,
  output soc_pkg::word_t ic_rdata_o,
  output logic           ic_rlast_o,
  input  logic           ext_awvalid_i,
  output logic           ext_awready_o,
  input  soc_pkg::addr_t ext_awaddr_i,
  input  logic           ext_wvalid_i,
  output logic           ext_wready_o,
  input  soc_pkg::word_t ext_wdata_i,
  input  soc_pkg::strb_t ext_wstrb_i,
  output logic           ext_bvalid_o,
  input  logic           ext_bready_i,
  output soc_pkg::resp_t ext_bresp_o,
  input  logic           ext_arvalid_i,
  output logic           ext_arready_o,
  input  soc_pkg::addr_t ext_araddr_i,
  output logic           ext_rvalid_o,
  input  logic           ext_rready_i,
  output soc_pkg::word_t ext_rdata_o,
  output soc_pkg::resp_t ext_rresp_o,
  output logic           master_awvalid_o,
  input  logic           master_awready_i,
  output soc_pkg::addr_t master_awaddr_o,
  output logic           master_wvalid_o,
  input  logic           master_wready_i,
  output soc_pkg::word_t master_wdata_o,
  output soc_pkg::strb_t master_wstrb_o,
  input  logic           master_bvalid_i,
  output logic           master_bready_o,
  input  soc_pkg::resp_t master_bresp_i,
  output logic           master_arvalid_o,
  input  logic           master_arready_i,
  output soc_pkg::addr_t master_araddr_o,
  output soc_pkg::len_t  master_arlen_o,
  input  logic           master_rvalid_i,
  output logic           master_rready_o,
  input  soc_pkg::word_t master_rdata_i,
  input  soc_pkg::resp_t master_rresp_i,
  input  logic           master_rlast_i
);

  logic busy_q;
  logic hold_q;
  logic owner_q;
  logic pick_data;

  // Only data traffic writes, so the write channels pass straight through
  assign master_awvalid_o = ext_awvalid_i;
  assign ext_awready_o    = master_awready_i;
  assign master_awaddr_o  = ext_awaddr_i;
  assign master_wvalid_o  = ext_wvalid_i;
  assign ext_wready_o     = master_wready_i;
  assign master_wdata_o   = ext_wdata_i;
  assign master_wstrb_o   = ext_wstrb_i;
  assign ext_bvalid_o     = master_bvalid_i;
  assign master_bready_o  = ext_bready_i;
  assign ext_bresp_o      = master_bresp_i;

  // Choice is frozen while an ar is waiting, so the master payload stays stable
  assign pick_data = (busy_q || hold_q) ? owner_q : ext_arvalid_i;

  assign master_arvalid_o = !busy_q && (pick_data ? ext_arvalid_i : ic_arvalid_i);
  assign master_araddr_o  = pick_data ? ext_araddr_i : ic_araddr_i;
  assign master_arlen_o   = pick_data ? '0 : soc_pkg::REFILL_LEN;
  assign ext_arready_o    = !busy_q && pick_data && master_arready_i;
  assign ic_arready_o     = !busy_q && !pick_data && master_arready_i;

  assign master_rready_o = busy_q && (owner_q ? ext_rready_i : ic_rready_i);
  assign ext_rvalid_o    = busy_q && owner_q && master_rvalid_i;
  assign ext_rdata_o     = master_rdata_i;
  assign ext_rresp_o     = master_rresp_i;
  assign ic_rvalid_o     = busy_q && !owner_q && master_rvalid_i;
  assign ic_rdata_o      = master_rdata_i;
  assign ic_rlast_o      = master_rlast_i;

  always_ff @(posedge clock) begin
    if (rst_i) begin
      busy_q  <= 1'b0;
      hold_q  <= 1'b0;
      owner_q <= 1'b0;
    end else begin
      if (master_arvalid_o) begin
        owner_q <= pick_data;
        hold_q  <= !master_arready_i;
        busy_q  <= master_arready_i;
      end else if (master_rvalid_i && master_rready_o && master_rlast_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  r_in_grant_a : assert property (@(posedge clock) disable iff (rst_i)
    master_rvalid_i |-> busy_q)
    else $error("read beat on master port with no grant held");

endmodule

// File: source/soc_icache.sv
`timescale 1ns/1ns

module soc_icache #(
  parameter int IC_INDEX_W = 4,
  localparam int TAG_W = 28 - IC_INDEX_W
) (
  input  logic           clock,
  input  logic           rst_i,
  input  logic           fetch_valid_i,
  input  soc_pkg::addr_t fetch_addr_i,
  output logic           fetch_done_o,
  output soc_pkg::word_t fetch_instr_o,
  output logic           ic_arvalid_o,
  input  logic           ic_arready_i,
  output soc_pkg::addr_t ic_araddr_o,
  input  logic           ic_rvalid_i,
  output logic           ic_rready_o,
  input  soc_pkg::word_t ic_rdata_i,
  input  logic           ic_rlast_i
);

  typedef enum logic [1:0] {
    IC_IDLE,
    IC_LOOKUP,
    IC_REFILL,
    IC_FILL
  } ic_state_t;

  ic_state_t                   state_q;
  logic [(1<<IC_INDEX_W)-1:0]  valid_q;
  logic                        ar_done_q;
  logic [1:0]                  beat_q;
  soc_pkg::addr_t              req_addr_q;
  soc_pkg::line_t              line_q;
  logic [IC_INDEX_W-1:0]       req_index;
  logic [TAG_W-1:0]            req_tag;
  logic [1:0]                  req_off;
  logic [IC_INDEX_W-1:0]       sram_index;
  logic                        sram_we;
  logic [TAG_W-1:0]            sram_rtag;
  soc_pkg::line_t              sram_rline;
  logic                        hit;
  logic                        beat_acc;

  assign req_index = req_addr_q[IC_INDEX_W+3:4];
  assign req_tag   = req_addr_q[31:IC_INDEX_W+4];
  assign req_off   = req_addr_q[3:2];

  // Index comes straight from the port in idle so lookup sees data next cycle
  assign sram_index = (state_q == IC_IDLE) ? fetch_addr_i[IC_INDEX_W+3:4] : req_index;
  assign sram_we    = (state_q == IC_FILL);

  soc_icache_sram #(
    .IC_INDEX_W(IC_INDEX_W)
  ) sram_i (
    .clock  (clock),
    .index_i(sram_index),
    .we_i   (sram_we),
    .wtag_i (req_tag),
    .wline_i(line_q),
    .rtag_o (sram_rtag),
    .rline_o(sram_rline)
  );

  assign hit      = valid_q[req_index] && (sram_rtag == req_tag);
  assign beat_acc = ic_rvalid_i && ic_rready_o;

  assign fetch_done_o  = ((state_q == IC_LOOKUP) && hit) || (state_q == IC_FILL);
  assign fetch_instr_o = (state_q == IC_FILL) ? line_q[req_off*32 +: 32]
                                              : sram_rline[req_off*32 +: 32];

  assign ic_arvalid_o = (state_q == IC_REFILL) && !ar_done_q;
  assign ic_araddr_o  = {req_addr_q[31:4], 4'b0000};
  assign ic_rready_o  = (state_q == IC_REFILL) && ar_done_q;

  always_ff @(posedge clock) begin
    if (rst_i) begin
      state_q   <= IC_IDLE;
      valid_q   <= '0;
      ar_done_q <= 1'b0;
      beat_q    <= 2'd0;
    end else begin
      case (state_q)
        IC_IDLE: begin
          if (fetch_valid_i) begin
            state_q <= IC_LOOKUP;
          end
        end
        IC_LOOKUP: begin
          ar_done_q <= 1'b0;
          beat_q    <= 2'd0;
          state_q   <= hit ? IC_IDLE : IC_REFILL;
        end
        IC_REFILL: begin
          if (ic_arvalid_o && ic_arready_i) begin
            ar_done_q <= 1'b1;
          end
          if (beat_acc) begin
            beat_q <= beat_q + 2'd1;
            if (ic_rlast_i) begin
              state_q <= IC_FILL;
            end
          end
        end
        IC_FILL: begin
          valid_q[req_index] <= 1'b1;
          state_q            <= IC_IDLE;
        end
        default: state_q <= IC_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if ((state_q == IC_IDLE) && fetch_valid_i) begin
      req_addr_q <= fetch_addr_i;
    end
    if (beat_acc) begin
      line_q[beat_q*32 +: 32] <= ic_rdata_i;
    end
  end

  // Fourth beat of a refill must carry rlast
  refill_len_a : assert property (@(posedge clock) disable iff (rst_i)
    beat_acc && (beat_q == 2'd3) |-> ic_rlast_i)
    else $error("icache refill longer than four beats");

endmodule

// File: source/soc_icache_sram.sv
`timescale 1ns/1ns

module soc_icache_sram #(
  parameter int IC_INDEX_W = 4,
  localparam int TAG_W = 28 - IC_INDEX_W
) (
  input  logic                  clock,
  input  logic [IC_INDEX_W-1:0] index_i,
  input  logic                  we_i,
  input  logic [TAG_W-1:0]      wtag_i,
  input  soc_pkg::line_t        wline_i,
  output logic [TAG_W-1:0]      rtag_o,
  output soc_pkg::line_t        rline_o
);

  localparam int DEPTH = 1 << IC_INDEX_W;

  logic [TAG_W-1:0] tag_mem[DEPTH];
  soc_pkg::line_t   line_mem[DEPTH];

  // Read returns the old entry when written in the same cycle
  always_ff @(posedge clock) begin
    if (we_i) begin
      tag_mem[index_i]  <= wtag_i;
      line_mem[index_i] <= wline_i;
    end
    rtag_o  <= tag_mem[index_i];
    rline_o <= line_mem[index_i];
  end

endmodule

// File: source/soc_pkg.sv
package soc_pkg;

  typedef logic [31:0]  addr_t;
  typedef logic [31:0]  word_t;
  typedef logic [3:0]   strb_t;
  typedef logic [1:0]   resp_t;
  typedef logic [7:0]   len_t;
  // Four words per cache line
  typedef logic [127:0] line_t;

  localparam resp_t RESP_OKAY = 2'b00;

  // CLINT window, 64 KiB
  localparam addr_t CLINT_BASE = 32'h0200_0000;
  localparam addr_t CLINT_MASK = 32'hffff_0000;

  localparam logic [3:0] MTIME_LO    = 4'h0;
  localparam logic [3:0] MTIME_HI    = 4'h4;
  localparam logic [3:0] MTIMECMP_LO = 4'h8;
  localparam logic [3:0] MTIMECMP_HI = 4'hc;

  // arlen for a full line refill
  localparam len_t REFILL_LEN = 8'd3;

endpackage
